/* sim.f */
common/cluster_pkg.sv
alloc/alloc_slot.sv
alloc/alloc_distributor.sv
logic/done_arbiter.sv
logic/tblock_scheduler.sv
tb/tb_clock_gen.sv
tb/tblock_scheduler_checker.sv
tb/tb_tblock_scheduler.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TOP        ?= tb_tblock_scheduler
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_tblock_scheduler.sv */
// ##########################################################################
// Testbench for the thread-block scheduler
// Plays the dispatcher and the compute units and checks both paths
// ##########################################################################

`timescale 1ns/10ps

module tb_tblock_scheduler;
    logic                                                 clk_i;
    logic                                                 arst_n_i;
    logic                                                 alloc_valid_i;
    cluster_pkg::alloc_req_t                              alloc_i;
    logic                                                 warp_free_o;
    cluster_pkg::unit_mask_t                              cu_alloc_valid_o;
    cluster_pkg::alloc_req_t [cluster_pkg::NumUnits-1:0] cu_alloc_o;
    cluster_pkg::unit_mask_t                              cu_warp_free_i;
    cluster_pkg::unit_mask_t                              cu_done_i;
    cluster_pkg::tgroup_id_t [cluster_pkg::NumUnits-1:0] cu_done_id_i;
    cluster_pkg::unit_mask_t                              cu_done_ready_o;
    logic                                                 tblock_done_o;
    cluster_pkg::tgroup_id_t                              tblock_done_id_o;
    logic                                                 tblock_done_ready_i;

    int unsigned             err_cnt;
    int unsigned             fail_cnt;
    int unsigned             rr_ptr;
    int unsigned             grant_cnt [cluster_pkg::NumUnits];
    logic [31:0]             rng_state;
    // Reference models for queued descriptors per unit and for pending and expected IDs
    cluster_pkg::alloc_req_t alloc_q [cluster_pkg::NumUnits][$];
    cluster_pkg::tgroup_id_t pend_q [cluster_pkg::NumUnits][$];
    cluster_pkg::tgroup_id_t out_q[$];
    cluster_pkg::tgroup_id_t seen_q[$];

    tb_clock_gen i_clock_gen (.clk_o(clk_i));

    tblock_scheduler uut (.*);

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cluster_pkg::alloc_req_t rand_desc();
        logic [95:0] bits;
        bits = {xorshift32(), xorshift32(), xorshift32()};
        return bits[$bits(cluster_pkg::alloc_req_t)-1:0];
    endfunction

    task automatic report_err(input string name, input logic [95:0] exp,
                              input logic [95:0] act);
        err_cnt++;
        $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic report_fail(input string msg);
        fail_cnt++;
        $display("%s", msg);
    endtask

    // Each unit shows the head of its model queue, and nothing when empty
    task automatic check_heads(input string name);
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            if (cu_alloc_valid_o[u] !== (alloc_q[u].size() != 0))
                report_err(name, 96'(alloc_q[u].size() != 0), 96'(cu_alloc_valid_o[u]));
            else if (alloc_q[u].size() != 0 && cu_alloc_o[u] !== alloc_q[u][0])
                report_err(name, 96'(alloc_q[u][0]), 96'(cu_alloc_o[u]));
        end
    endtask

    // One clock of the completion side with the unit models and the expected grant
    task automatic done_cycle(input string name, input bit rand_mode);
        cluster_pkg::unit_mask_t exp_grant;
        cluster_pkg::unit_mask_t got;
        logic [31:0]             rnd;
        int unsigned             idx;
        @(negedge clk_i);
        if (tblock_done_o !== (out_q.size() != 0))
            report_err(name, 96'(out_q.size() != 0), 96'(tblock_done_o));
        if (tblock_done_o && tblock_done_ready_i) begin
            seen_q.push_back(tblock_done_id_o);
            if (out_q.size() == 0) begin
                report_fail({name, ": an ID came out with no grant behind it"});
            end else begin
                if (tblock_done_id_o !== out_q[0])
                    report_err(name, 96'(out_q[0]), 96'(tblock_done_id_o));
                void'(out_q.pop_front());
            end
        end
        // Search starts after the last winner, only while the output can take an ID
        exp_grant = '0;
        if (out_q.size() == 0 || tblock_done_ready_i) begin
            for (int i = 0; i < cluster_pkg::NumUnits; i++) begin
                idx = (rr_ptr + i) % cluster_pkg::NumUnits;
                if (cu_done_i[idx]) begin
                    exp_grant[idx] = 1'b1;
                    out_q.push_back(cu_done_id_i[idx]);
                    rr_ptr = (idx + 1) % cluster_pkg::NumUnits;
                    break;
                end
            end
        end
        got = cu_done_ready_o;
        if (got !== exp_grant) report_err(name, 96'(exp_grant), 96'(got));
        rnd = xorshift32();
        @(posedge clk_i);
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            if (got[u]) grant_cnt[u]++;
            if (got[u] && cu_done_i[u]) void'(pend_q[u].pop_front());
            // A raised request holds until it is granted
            if (!cu_done_i[u] || got[u]) begin
                cu_done_i[u]    <= (pend_q[u].size() != 0) && (!rand_mode || rnd[u]);
                cu_done_id_i[u] <= (pend_q[u].size() != 0) ? pend_q[u][0] : '0;
            end
        end
        tblock_done_ready_i <= rand_mode ? rnd[8] : 1'b1;
    endtask

    task automatic test_reset_state();
        @(negedge clk_i);
        if (cu_alloc_valid_o !== '0) report_err("reset_state", 96'(0), 96'(cu_alloc_valid_o));
        if (tblock_done_o !== 1'b0) report_err("reset_state", 96'(0), 96'(tblock_done_o));
        if (cu_done_ready_o !== '0) report_err("reset_state", 96'(0), 96'(cu_done_ready_o));
        if (warp_free_o !== 1'b1) report_err("reset_state", 96'(1), 96'(warp_free_o));
    endtask

    task automatic test_first_free();
        cluster_pkg::alloc_req_t desc;
        int unsigned             tgt;
        for (int i = 0; i < 9; i++) begin
            desc = rand_desc();
            tgt  = cluster_pkg::NumUnits;
            for (int u = cluster_pkg::NumUnits - 1; u >= 0; u--) begin
                if (alloc_q[u].size() < cluster_pkg::SlotDepth) tgt = u;
            end
            @(posedge clk_i);
            alloc_valid_i <= 1'b1;
            alloc_i       <= desc;
            @(negedge clk_i);
            check_heads("first_free");
            if (warp_free_o !== (tgt < cluster_pkg::NumUnits))
                report_err("first_free", 96'(tgt < cluster_pkg::NumUnits), 96'(warp_free_o));
            if (tgt < cluster_pkg::NumUnits) alloc_q[tgt].push_back(desc);
        end
        @(posedge clk_i);
        alloc_valid_i <= 1'b0;
        @(negedge clk_i);
        check_heads("first_free");
    endtask

    task automatic test_alloc_order();
        int unsigned cyc;
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            // Stalled heads must hold
            repeat (3) begin
                @(negedge clk_i);
                check_heads("alloc_order");
            end
            @(posedge clk_i);
            cu_warp_free_i <= cluster_pkg::unit_mask_t'(1) << u;
            cyc = 0;
            while (alloc_q[u].size() != 0 && cyc < 10) begin
                @(negedge clk_i);
                check_heads("alloc_order");
                if (cu_alloc_valid_o[u] && cu_warp_free_i[u]) void'(alloc_q[u].pop_front());
                cyc++;
            end
            if (alloc_q[u].size() != 0)
                report_fail("alloc_order: a unit did not receive its descriptors in time");
            @(posedge clk_i);
            cu_warp_free_i <= '0;
        end
        @(negedge clk_i);
        check_heads("alloc_order");
        if (warp_free_o !== 1'b1) report_err("alloc_order", 96'(1), 96'(warp_free_o));
    endtask

    task automatic test_rr_order();
        int unsigned cyc;
        seen_q.delete();
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            pend_q[u].push_back(cluster_pkg::tgroup_id_t'(8'ha0 + u));
            grant_cnt[u] = 0;
        end
        cyc = 0;
        while (seen_q.size() < cluster_pkg::NumUnits && cyc < 20) begin
            done_cycle("rr_order", 1'b0);
            cyc++;
        end
        if (seen_q.size() != cluster_pkg::NumUnits)
            report_fail("rr_order: not every unit's ID came out");
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            if (seen_q.size() > u && seen_q[u] !== cluster_pkg::tgroup_id_t'(8'ha0 + u))
                report_err("rr_order", 96'(8'ha0 + u), 96'(seen_q[u]));
            if (grant_cnt[u] != 1) report_err("rr_order", 96'(1), 96'(grant_cnt[u]));
        end
    endtask

    task automatic test_done_backpressure();
        int unsigned cyc;
        int unsigned total;
        seen_q.delete();
        total = 0;
        for (int u = 0; u < cluster_pkg::NumUnits; u++) begin
            repeat (6) begin
                pend_q[u].push_back(cluster_pkg::tgroup_id_t'(xorshift32()));
                total++;
            end
        end
        cyc = 0;
        while (seen_q.size() < total && cyc < 400) begin
            done_cycle("done_backpressure", 1'b1);
            cyc++;
        end
        // A few idle cycles catch any repeated ID
        repeat (4) done_cycle("done_backpressure", 1'b1);
        if (seen_q.size() != total)
            report_fail("done_backpressure: IDs were lost or reported more than once");
    endtask

    // About 4000 cycles, well above the length of all tests together
    initial begin
        #(4000 * 20);
        $display("Watchdog: the run did not finish within 4000 clock cycles");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rng_state = 32'h9f19_435b;
        err_cnt   = 0;
        fail_cnt  = 0;
        rr_ptr    = 0;
        arst_n_i            <= 1'b0;
        alloc_valid_i       <= 1'b0;
        alloc_i             <= '0;
        cu_warp_free_i      <= '0;
        cu_done_i           <= '0;
        cu_done_id_i        <= '0;
        tblock_done_ready_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        test_reset_state();
        test_first_free();
        test_alloc_order();
        test_rr_order();
        test_done_backpressure();
        $display("Result: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end
endmodule : tb_tblock_scheduler

/* tb/tblock_scheduler_checker.sv */
// ##########################################################################
// Handshake assertions for the thread-block scheduler, bound to the DUT
// ##########################################################################

`timescale 1ns/10ps

module tblock_scheduler_checker (
    input logic                                                 clk_i,
    input logic                                                 arst_n_i,
    input cluster_pkg::unit_mask_t                              cu_alloc_valid_o,
    input cluster_pkg::alloc_req_t [cluster_pkg::NumUnits-1:0] cu_alloc_o,
    input cluster_pkg::unit_mask_t                              cu_warp_free_i,
    input cluster_pkg::unit_mask_t                              cu_done_i,
    input cluster_pkg::unit_mask_t                              cu_done_ready_o,
    input logic                                                 tblock_done_o,
    input cluster_pkg::tgroup_id_t                              tblock_done_id_o,
    input logic                                                 tblock_done_ready_i
);
    // Completion output and its ID hold until taken
    done_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tblock_done_o && !tblock_done_ready_i |=> tblock_done_o && $stable(tblock_done_id_o))
        else $error("completion output changed before it was accepted");

    for (genvar cu = 0; cu < cluster_pkg::NumUnits; cu++) begin : gen_alloc_hold
        alloc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            cu_alloc_valid_o[cu] && !cu_warp_free_i[cu]
            |=> cu_alloc_valid_o[cu] && $stable(cu_alloc_o[cu]))
            else $error("descriptor toward unit %0d changed before it was accepted", cu);
    end : gen_alloc_hold

    // At most one grant, and only toward a requesting unit
    grant_ok: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(cu_done_ready_o) && ((cu_done_ready_o & ~cu_done_i) == '0))
        else $error("completion grant is not one-hot or goes to an idle unit");
endmodule : tblock_scheduler_checker

bind tblock_scheduler tblock_scheduler_checker i_checker (.*);

/* tb/tb_clock_gen.sv */
// ##########################################################################
// Free-running 20 ns testbench clock
// ##########################################################################

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o
);
    initial clk_o = 1'b0;
    always #10 clk_o = ~clk_o;
endmodule : tb_clock_gen

/* logic/tblock_scheduler.sv */
// #########################################################################
// Thread-block scheduler top level
// Joins the allocation distributor and the completion arbiter
// #########################################################################

`timescale 1ns/10ps

module tblock_scheduler (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,

    // Dispatcher allocation interface
    input  logic                                                 alloc_valid_i,
    input  cluster_pkg::alloc_req_t                              alloc_i,
    output logic                                                 warp_free_o,

    // Per-unit allocation interface
    output cluster_pkg::unit_mask_t                              cu_alloc_valid_o,
    output cluster_pkg::alloc_req_t [cluster_pkg::NumUnits-1:0] cu_alloc_o,
    input  cluster_pkg::unit_mask_t                              cu_warp_free_i,

    // Per-unit completion interface
    input  cluster_pkg::unit_mask_t                              cu_done_i,
    input  cluster_pkg::tgroup_id_t [cluster_pkg::NumUnits-1:0] cu_done_id_i,
    output cluster_pkg::unit_mask_t                              cu_done_ready_o,

    // Cluster completion output
    output logic                                                 tblock_done_o,
    output cluster_pkg::tgroup_id_t                              tblock_done_id_o,
    input  logic                                                 tblock_done_ready_i
);

    // ######################################################################
    // # Allocation path
    // ######################################################################

    alloc_distributor i_alloc_distributor (
        .clk_i           ( clk_i            ),
        .arst_n_i        ( arst_n_i         ),

        .alloc_valid_i   ( alloc_valid_i    ),
        .alloc_i         ( alloc_i          ),
        .warp_free_o     ( warp_free_o      ),

        .cu_alloc_valid_o( cu_alloc_valid_o ),
        .cu_alloc_o      ( cu_alloc_o       ),
        .cu_warp_free_i  ( cu_warp_free_i   )
    );

    // ######################################################################
    // # Completion path
    // ######################################################################

    done_arbiter i_done_arbiter (
        .clk_i              ( clk_i               ),
        .arst_n_i           ( arst_n_i            ),

        .cu_done_i          ( cu_done_i           ),
        .cu_done_id_i       ( cu_done_id_i        ),
        .cu_done_ready_o    ( cu_done_ready_o     ),

        .tblock_done_o      ( tblock_done_o       ),
        .tblock_done_id_o   ( tblock_done_id_o    ),
        .tblock_done_ready_i( tblock_done_ready_i )
    );

endmodule : tblock_scheduler

/* logic/done_arbiter.sv */
// #########################################################################
// Thread-block completion arbiter
// Round-robin over unit done reports, one group ID per cycle into a register
// #########################################################################

`timescale 1ns/10ps

module done_arbiter (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,

    // Compute unit side
    input  cluster_pkg::unit_mask_t                              cu_done_i,
    input  cluster_pkg::tgroup_id_t [cluster_pkg::NumUnits-1:0] cu_done_id_i,
    output cluster_pkg::unit_mask_t                              cu_done_ready_o,

    // Completion output
    output logic                                                 tblock_done_o,
    output cluster_pkg::tgroup_id_t                              tblock_done_id_o,
    input  logic                                                 tblock_done_ready_i
);
    logic [$clog2(cluster_pkg::NumUnits)-1:0] rr_ptr_q, rr_ptr_d, winner;
    logic                                     found;
    logic                                     can_accept;
    logic                                     grant;
    logic                                     done_valid_q;
    cluster_pkg::tgroup_id_t                  done_id_q;

    // ######################################################################
    // # Round-robin search
    // ######################################################################

    always_comb begin : rr_search
        int unsigned idx;
        int unsigned nxt;
        found    = 1'b0;
        winner   = '0;
        rr_ptr_d = rr_ptr_q;
        // Walk the units starting at the pointer, wrapping around
        for (int unsigned i = 0; i < cluster_pkg::NumUnits; i++) begin
            idx = (rr_ptr_q + i) % cluster_pkg::NumUnits;
            nxt = (idx + 1) % cluster_pkg::NumUnits;
            if (!found && cu_done_i[idx]) begin
                found    = 1'b1;
                winner   = idx[$bits(winner)-1:0];
                rr_ptr_d = nxt[$bits(rr_ptr_d)-1:0];
            end
        end
    end : rr_search

    // Output register takes a new ID when empty or draining this cycle
    assign can_accept = !done_valid_q || tblock_done_ready_i;
    assign grant      = found && can_accept;

    assign cu_done_ready_o = grant ? (cluster_pkg::unit_mask_t'(1) << winner) : '0;

    // ######################################################################
    // # Output register
    // ######################################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q     <= '0;
            done_valid_q <= 1'b0;
        end else begin
            if (grant) begin
                rr_ptr_q     <= rr_ptr_d;
                done_valid_q <= 1'b1;
            end else if (tblock_done_ready_i) begin
                done_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) done_id_q <= cu_done_id_i[winner];
    end

    assign tblock_done_o    = done_valid_q;
    assign tblock_done_id_o = done_id_q;

endmodule : done_arbiter

/* alloc/alloc_distributor.sv */
// #########################################################################
// Thread-block distributor
// Sends each accepted descriptor to the lowest compute unit with buffer room
// #########################################################################

`timescale 1ns/10ps

module alloc_distributor (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,

    // Dispatcher side
    input  logic                                                 alloc_valid_i,
    input  cluster_pkg::alloc_req_t                              alloc_i,
    output logic                                                 warp_free_o,

    // Compute unit side
    output cluster_pkg::unit_mask_t                              cu_alloc_valid_o,
    output cluster_pkg::alloc_req_t [cluster_pkg::NumUnits-1:0] cu_alloc_o,
    input  cluster_pkg::unit_mask_t                              cu_warp_free_i
);
    cluster_pkg::unit_mask_t space;
    cluster_pkg::unit_mask_t push;

    // ######################################################################
    // # First-free selection
    // ######################################################################

    // Space bits come from registered buffer state only
    assign warp_free_o = |space;

    always_comb begin : pick_first_free
        push = '0;
        for (int unsigned cu = 0; cu < cluster_pkg::NumUnits; cu++) begin
            // Only the lowest unit with room takes the descriptor
            if (alloc_valid_i && space[cu] && (push == '0)) begin
                push[cu] = 1'b1;
            end
        end
    end : pick_first_free

    // ######################################################################
    // # Per-unit holding buffers
    // ######################################################################

    for (genvar cu = 0; cu < cluster_pkg::NumUnits; cu++) begin : gen_slot
        alloc_slot i_alloc_slot (
            .clk_i   ( clk_i               ),
            .arst_n_i( arst_n_i            ),

            .push_i  ( push[cu]            ),
            .data_i  ( alloc_i             ),
            .space_o ( space[cu]           ),

            .valid_o ( cu_alloc_valid_o[cu] ),
            .data_o  ( cu_alloc_o[cu]       ),
            .ready_i ( cu_warp_free_i[cu]   )
        );
    end : gen_slot

endmodule : alloc_distributor

/* alloc/alloc_slot.sv */
// #########################################################################
// Two-entry descriptor holding buffer for one compute unit
// #########################################################################

`timescale 1ns/10ps

module alloc_slot (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    push_i,
    input  cluster_pkg::alloc_req_t data_i,
    output logic                    space_o,
    output logic                    valid_o,
    output cluster_pkg::alloc_req_t data_o,
    input  logic                    ready_i
);
    cluster_pkg::slot_state_e                              state_d, state_q;
    cluster_pkg::alloc_req_t [cluster_pkg::SlotDepth-1:0] mem_q;
    logic [$clog2(cluster_pkg::SlotDepth)-1:0]            wr_ptr_q, rd_ptr_q;
    logic                                                  wr_en, rd_en;

    assign space_o = (state_q != cluster_pkg::SLOT_FULL);
    assign valid_o = (state_q != cluster_pkg::SLOT_EMPTY);
    assign data_o  = mem_q[rd_ptr_q];

    // A push into a full buffer is dropped
    assign wr_en = push_i & space_o;
    assign rd_en = valid_o & ready_i;

    always_comb begin : next_state
        state_d = state_q;
        unique case (state_q)
            cluster_pkg::SLOT_EMPTY: begin
                if (wr_en) state_d = cluster_pkg::SLOT_ONE;
            end
            cluster_pkg::SLOT_ONE: begin
                if (wr_en && !rd_en) state_d = cluster_pkg::SLOT_FULL;
                else if (!wr_en && rd_en) state_d = cluster_pkg::SLOT_EMPTY;
            end
            cluster_pkg::SLOT_FULL: begin
                if (rd_en) state_d = cluster_pkg::SLOT_ONE;
            end
            default: state_d = cluster_pkg::SLOT_EMPTY;
        endcase
    end : next_state

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= cluster_pkg::SLOT_EMPTY;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            state_q <= state_d;
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Descriptor storage
    always_ff @(posedge clk_i) begin
        if (wr_en) mem_q[wr_ptr_q] <= data_i;
    end

endmodule : alloc_slot

/* common/cluster_pkg.sv */
// #########################################################################
// Thread-block scheduler shared definitions
// Cluster sizes, descriptor field types and the holding buffer state encoding
// #########################################################################

package cluster_pkg;

    // #####################################################################
    // # Cluster sizes
    // #####################################################################

    localparam int unsigned NumUnits       = 4;
    localparam int unsigned PcWidth        = 16;
    localparam int unsigned AddrWidth      = 32;
    localparam int unsigned WarpWidth      = 4;
    localparam int unsigned TblockIdxBits  = 8;
    localparam int unsigned TgroupIdBits   = 8;
    // Block size counts up to a full warp, so one bit more than log2
    localparam int unsigned TblockSizeBits = $clog2(WarpWidth) + 1;
    localparam int unsigned SlotDepth      = 2;

    // #####################################################################
    // # Field types
    // #####################################################################

    typedef logic [PcWidth-1:0]        pc_t;
    typedef logic [AddrWidth-1:0]      addr_t;
    typedef logic [TblockIdxBits-1:0]  tblock_idx_t;
    typedef logic [TblockSizeBits-1:0] tblock_size_t;
    typedef logic [TgroupIdBits-1:0]   tgroup_id_t;
    typedef logic [NumUnits-1:0]       unit_mask_t;

    // One thread-block descriptor as issued by the dispatcher
    typedef struct packed {
        pc_t          pc;
        addr_t        dp_addr;
        tblock_idx_t  tblock_idx;
        tblock_size_t tblock_size;
        tgroup_id_t   tgroup_id;
    } alloc_req_t;

    // Fill level of a per-unit holding buffer
    typedef enum logic [1:0] {
        SLOT_EMPTY,
        SLOT_ONE,
        SLOT_FULL
    } slot_state_e;

endpackage : cluster_pkg
